// File: design/soc_pkg.sv
package soc_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // main memory window, 4 KB
    localparam logic [ADDR_W-1:0] RAM_BASE = 32'h8000_0000;
    localparam int unsigned RAM_WORDS = 1024;
    localparam int RAM_AW = $clog2(RAM_WORDS);

    // uart window
    localparam logic [ADDR_W-1:0] UART_BASE = 32'h1000_0000;
    localparam int unsigned UART_SIZE = 16;
    localparam logic [ADDR_W-1:0] UART_DATA_OFF = 32'h0000_0000;
    localparam logic [ADDR_W-1:0] UART_STAT_OFF = 32'h0000_0004;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              write;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] strb;
    } bus_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              err;
    } bus_resp_t;

    typedef struct packed {
        logic [ADDR_W-1:0] paddr;
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [DATA_W-1:0] pwdata;
        logic [STRB_W-1:0] pstrb;
    } apb_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_resp_t;

    typedef enum logic [1:0] {
        ROUTE_MEM,
        ROUTE_PERI,
        ROUTE_NONE
    } route_e;

    typedef enum logic [1:0] {
        APB_IDLE,
        APB_SETUP,
        APB_ACCESS
    } apb_state_e;

endpackage

// File: design/reset_sync.sv
`timescale 1ns/10ps

module reset_sync (
    input  logic clock,
    input  logic rst_i,
    output logic rst_o
);
    logic [1:0] sync_q;
    logic [1:0] delay_q;

    // two flops to bring rst_i into the clock domain
    always_ff @(posedge clock) begin
        sync_q <= {sync_q[0], rst_i};
    end

    // extra delay so the domain comes up a little later
    always_ff @(posedge clock) begin
        delay_q <= {delay_q[0], sync_q[1]};
    end

    assign rst_o = delay_q[1];

endmodule

// File: design/addr_decode.sv
`timescale 1ns/10ps

module addr_decode (
    input  logic               clock,
    input  logic               rst_i,
    input  logic               req_valid_i,
    input  soc_pkg::bus_req_t  req_i,
    output logic               req_ready_o,
    output logic               resp_valid_o,
    output soc_pkg::bus_resp_t resp_o,
    output logic               mem_valid_o,
    output soc_pkg::bus_req_t  mem_req_o,
    input  logic               mem_resp_valid_i,
    input  soc_pkg::bus_resp_t mem_resp_i,
    output logic               peri_valid_o,
    output soc_pkg::bus_req_t  peri_req_o,
    input  logic               peri_done_i,
    input  soc_pkg::bus_resp_t peri_resp_i
);
    import soc_pkg::*;

    logic [ADDR_W-1:0] ram_off;
    logic [ADDR_W-1:0] uart_off;
    route_e            route_d;
    route_e            route_q;
    bus_req_t          req_q;
    logic              accept;
    logic              run_q;
    logic              busy_q;
    logic              acc_q;
    logic              err_q;

    assign ram_off = req_i.addr - RAM_BASE;
    assign uart_off = req_i.addr - UART_BASE;

    always_comb begin
        if (ram_off < RAM_WORDS * 4) begin
            route_d = ROUTE_MEM;
        end else if (uart_off < UART_SIZE) begin
            route_d = ROUTE_PERI;
        end else begin
            route_d = ROUTE_NONE;
        end
    end

    // port frees up in the cycle the response goes out
    assign req_ready_o = run_q & (~busy_q | resp_valid_o);
    assign accept = req_valid_i & req_ready_o;

    always_ff @(posedge clock) begin
        if (accept) begin
            req_q <= req_i;
        end
    end

    always_ff @(posedge clock) begin
        if (rst_i) begin
            run_q        <= 1'b0;
            busy_q       <= 1'b0;
            acc_q        <= 1'b0;
            err_q        <= 1'b0;
            mem_valid_o  <= 1'b0;
            peri_valid_o <= 1'b0;
            route_q      <= ROUTE_NONE;
        end else begin
            run_q        <= 1'b1;
            acc_q        <= accept;
            // launch one cycle after accept
            mem_valid_o  <= acc_q && (route_q == ROUTE_MEM);
            peri_valid_o <= acc_q && (route_q == ROUTE_PERI);
            err_q        <= acc_q && (route_q == ROUTE_NONE);
            if (accept) begin
                busy_q  <= 1'b1;
                route_q <= route_d;
            end else if (resp_valid_o) begin
                busy_q <= 1'b0;
            end
        end
    end

    assign mem_req_o = req_q;
    assign peri_req_o = req_q;

    // response merge
    assign resp_valid_o = err_q | mem_resp_valid_i | peri_done_i;

    always_comb begin
        case (route_q)
            ROUTE_MEM: begin
                resp_o = mem_resp_i;
            end
            ROUTE_PERI: begin
                resp_o = peri_resp_i;
            end
            default: begin
                resp_o.rdata = '0;
                resp_o.err   = 1'b1;
            end
        endcase
    end

endmodule

// File: design/apb_bridge.sv
`timescale 1ns/10ps

module apb_bridge (
    input  logic               clock,
    input  logic               rst_i,
    input  logic               peri_valid_i,
    input  soc_pkg::bus_req_t  peri_req_i,
    output logic               peri_done_o,
    output soc_pkg::bus_resp_t peri_resp_o,
    output soc_pkg::apb_req_t  apb_req_o,
    input  soc_pkg::apb_resp_t apb_resp_i
);
    import soc_pkg::*;

    apb_state_e state_q;
    bus_req_t   hold_q;
    logic       start;
    logic       finish;

    assign start = (state_q == APB_IDLE) && peri_valid_i;
    assign finish = (state_q == APB_ACCESS) && apb_resp_i.pready;

    always_ff @(posedge clock) begin
        if (rst_i) begin
            state_q     <= APB_IDLE;
            peri_done_o <= 1'b0;
        end else begin
            peri_done_o <= finish;
            case (state_q)
                APB_IDLE: begin
                    if (peri_valid_i) begin
                        state_q <= APB_SETUP;
                    end
                end
                APB_SETUP: begin
                    state_q <= APB_ACCESS;
                end
                APB_ACCESS: begin
                    // wait states until the slave is ready
                    if (apb_resp_i.pready) begin
                        state_q <= APB_IDLE;
                    end
                end
                default: begin
                    state_q <= APB_IDLE;
                end
            endcase
        end
    end

    // request stays put for the whole transfer
    always_ff @(posedge clock) begin
        if (start) begin
            hold_q <= peri_req_i;
        end
    end

    always_ff @(posedge clock) begin
        if (finish) begin
            peri_resp_o.rdata <= apb_resp_i.prdata;
            peri_resp_o.err   <= apb_resp_i.pslverr;
        end
    end

    always_comb begin
        apb_req_o.paddr   = hold_q.addr - UART_BASE;
        apb_req_o.psel    = (state_q != APB_IDLE);
        apb_req_o.penable = (state_q == APB_ACCESS);
        apb_req_o.pwrite  = hold_q.write;
        apb_req_o.pwdata  = hold_q.wdata;
        apb_req_o.pstrb   = hold_q.strb;
    end

endmodule

// File: design/sim_uart.sv
`timescale 1ns/10ps

module sim_uart (
    input  logic               clock,
    input  logic               rst_i,
    input  soc_pkg::apb_req_t  apb_req_i,
    output soc_pkg::apb_resp_t apb_resp_o,
    output logic               uart_out_valid_o,
    output logic [7:0]         uart_out_ch_o,
    output logic               uart_in_valid_o,
    input  logic [7:0]         uart_in_ch_i
);
    import soc_pkg::*;

    logic [DATA_W-1:0] wr_count_q;
    logic              access;
    logic              off_data;
    logic              off_stat;

    assign access = apb_req_i.psel & apb_req_i.penable;
    assign off_data = (apb_req_i.paddr == UART_DATA_OFF);
    assign off_stat = (apb_req_i.paddr == UART_STAT_OFF);

    // strobes only in the access phase
    assign uart_out_valid_o = access & apb_req_i.pwrite & off_data;
    assign uart_out_ch_o = apb_req_i.pwdata[7:0];
    assign uart_in_valid_o = access & ~apb_req_i.pwrite & off_data;

    always_comb begin
        apb_resp_o.pready  = 1'b1;
        apb_resp_o.pslverr = ~(off_data | off_stat);
        apb_resp_o.prdata  = '0;
        if (!apb_req_i.pwrite) begin
            if (off_data) begin
                apb_resp_o.prdata = {{(DATA_W - 8){1'b0}}, uart_in_ch_i};
            end else if (off_stat) begin
                apb_resp_o.prdata = wr_count_q;
            end
        end
    end

    // chars sent since reset
    always_ff @(posedge clock) begin
        if (rst_i) begin
            wr_count_q <= '0;
        end else if (uart_out_valid_o) begin
            wr_count_q <= wr_count_q + 1'b1;
        end
    end

endmodule

// File: design/sim_ram.sv
`timescale 1ns/10ps

module sim_ram (
    input  logic               clock,
    input  logic               rst_i,
    input  logic               mem_valid_i,
    input  soc_pkg::bus_req_t  mem_req_i,
    output logic               mem_resp_valid_o,
    output soc_pkg::bus_resp_t mem_resp_o
);
    import soc_pkg::*;

    logic [DATA_W-1:0] mem [RAM_WORDS];
    logic [RAM_AW-1:0] idx;

    // word index, byte offset dropped
    assign idx = mem_req_i.addr[2 +: RAM_AW];

    always_ff @(posedge clock) begin
        if (mem_valid_i) begin
            if (mem_req_i.write) begin
                for (int b = 0; b < STRB_W; b++) begin
                    if (mem_req_i.strb[b]) begin
                        mem[idx][8*b +: 8] <= mem_req_i.wdata[8*b +: 8];
                    end
                end
                mem_resp_o.rdata <= '0;
            end else begin
                mem_resp_o.rdata <= mem[idx];
            end
            mem_resp_o.err <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (rst_i) begin
            mem_resp_valid_o <= 1'b0;
        end else begin
            mem_resp_valid_o <= mem_valid_i;
        end
    end

endmodule

// File: design/sim_top.sv
`timescale 1ns/10ps

module sim_top (
    input  logic               clock,
    input  logic               rst_i,
    input  logic               req_valid_i,
    input  soc_pkg::bus_req_t  req_i,
    output logic               req_ready_o,
    output logic               resp_valid_o,
    output soc_pkg::bus_resp_t resp_o,
    output logic               uart_out_valid_o,
    output logic [7:0]         uart_out_ch_o,
    output logic               uart_in_valid_o,
    input  logic [7:0]         uart_in_ch_i
);
    import soc_pkg::*;

    logic      core_rst;
    logic      peri_rst;
    logic      mem_valid;
    bus_req_t  mem_req;
    logic      mem_resp_valid;
    bus_resp_t mem_resp;
    logic      peri_valid;
    bus_req_t  peri_req;
    logic      peri_done;
    bus_resp_t peri_resp;
    apb_req_t  apb_req;
    apb_resp_t apb_resp;

    // separate resets for core side and peripherals
    reset_sync rst_core_i (
        .clock (clock),
        .rst_i (rst_i),
        .rst_o (core_rst)
    );

    reset_sync rst_peri_i (
        .clock (clock),
        .rst_i (rst_i),
        .rst_o (peri_rst)
    );

    addr_decode addr_decode_i (
        .clock            (clock),
        .rst_i            (core_rst),
        .req_valid_i      (req_valid_i),
        .req_i            (req_i),
        .req_ready_o      (req_ready_o),
        .resp_valid_o     (resp_valid_o),
        .resp_o           (resp_o),
        .mem_valid_o      (mem_valid),
        .mem_req_o        (mem_req),
        .mem_resp_valid_i (mem_resp_valid),
        .mem_resp_i       (mem_resp),
        .peri_valid_o     (peri_valid),
        .peri_req_o       (peri_req),
        .peri_done_i      (peri_done),
        .peri_resp_i      (peri_resp)
    );

    apb_bridge apb_bridge_i (
        .clock        (clock),
        .rst_i        (peri_rst),
        .peri_valid_i (peri_valid),
        .peri_req_i   (peri_req),
        .peri_done_o  (peri_done),
        .peri_resp_o  (peri_resp),
        .apb_req_o    (apb_req),
        .apb_resp_i   (apb_resp)
    );

    sim_uart sim_uart_i (
        .clock            (clock),
        .rst_i            (peri_rst),
        .apb_req_i        (apb_req),
        .apb_resp_o       (apb_resp),
        .uart_out_valid_o (uart_out_valid_o),
        .uart_out_ch_o    (uart_out_ch_o),
        .uart_in_valid_o  (uart_in_valid_o),
        .uart_in_ch_i     (uart_in_ch_i)
    );

    sim_ram sim_ram_i (
        .clock            (clock),
        .rst_i            (core_rst),
        .mem_valid_i      (mem_valid),
        .mem_req_i        (mem_req),
        .mem_resp_valid_o (mem_resp_valid),
        .mem_resp_o       (mem_resp)
    );

endmodule

// File: bench/tb_sim_top.sv
`timescale 1ns/10ps

module tb_sim_top;
    import soc_pkg::*;

    localparam int TIMEOUT = 64;

    logic       clock;
    logic       rst_i;
    logic       req_valid_i;
    bus_req_t   req_i;
    logic       req_ready_o;
    logic       resp_valid_o;
    bus_resp_t  resp_o;
    logic       uart_out_valid_o;
    logic [7:0] uart_out_ch_o;
    logic       uart_in_valid_o;
    logic [7:0] uart_in_ch_i;

    logic [15:0]       lfsr;
    logic [DATA_W-1:0] model_mem [RAM_WORDS];
    int                uart_count;
    int                test_errors;
    int                errors;
    int                passed;
    int                failed;

    sim_top sim_top_i (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // fibonacci lfsr, taps 16 14 13 11
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic report_timeout(input string what);
        $display("timeout: the DUT never %s", what);
        $display("FAIL: see errors above");
        $finish;
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            $display("test %s: ok", name);
            passed++;
        end else begin
            $display("test %s: %0d errors", name, test_errors);
            failed++;
        end
        errors += test_errors;
        test_errors = 0;
    endtask

    task automatic run_op(input logic [31:0] addr, input logic write,
                          input logic [31:0] wdata, input logic [3:0] strb);
        logic [31:0] exp_rdata;
        logic        exp_err;
        int          exp_out;
        int          exp_in;
        int          exp_lat;
        int          n_out;
        int          n_in;
        int          cnt;
        logic [7:0]  out_ch;
        uart_in_ch_i = take_bits(8);
        exp_rdata = '0;
        exp_err = 1'b0;
        exp_out = 0;
        exp_in = 0;
        exp_lat = 0;
        if (addr >= RAM_BASE && addr < RAM_BASE + RAM_WORDS * 4) begin
            for (int b = 0; b < 4; b++) begin
                if (write && strb[b]) begin
                    model_mem[addr[11:2]][8*b +: 8] = wdata[8*b +: 8];
                end
            end
            exp_rdata = write ? '0 : model_mem[addr[11:2]];
            exp_lat = 2;
        end else if (addr == UART_BASE + UART_DATA_OFF) begin
            exp_out = write;
            exp_in = !write;
            exp_rdata = write ? '0 : {24'h0, uart_in_ch_i};
        end else if (addr == UART_BASE + UART_STAT_OFF) begin
            exp_rdata = write ? '0 : uart_count;
        end else begin
            // unmapped, or a hole in the uart window
            exp_err = 1'b1;
            // holes answer through the bridge, so no fixed latency there
            if (addr < UART_BASE || addr >= UART_BASE + UART_SIZE) begin
                exp_lat = 1;
            end
        end
        req_i = '{addr: addr, write: write, wdata: wdata, strb: strb};
        req_valid_i = 1'b1;
        cnt = 0;
        @(negedge clock);
        while (req_ready_o !== 1'b1 && cnt < TIMEOUT) begin
            cnt++;
            @(negedge clock);
        end
        if (req_ready_o !== 1'b1) begin
            report_timeout("raised req_ready_o for a request");
        end
        @(posedge clock);
        #1;
        req_valid_i = 1'b0;
        n_out = 0;
        n_in = 0;
        out_ch = '0;
        cnt = 0;
        @(negedge clock);
        while (resp_valid_o !== 1'b1 && cnt < TIMEOUT) begin
            if (req_ready_o !== 1'b0) begin
                $display("** Error @ %0t: req_ready_o high while %h is outstanding",
                         $time, addr);
                test_errors++;
            end
            if (uart_out_valid_o) begin
                n_out++;
                out_ch = uart_out_ch_o;
            end
            n_in += uart_in_valid_o;
            cnt++;
            @(negedge clock);
        end
        if (resp_valid_o !== 1'b1) begin
            report_timeout("returned a response");
        end
        if (exp_lat != 0 && cnt != exp_lat) begin
            $display("** Error @ %0t: response to %h after %0d cycles, expected %0d",
                     $time, addr, cnt, exp_lat);
            test_errors++;
        end
        if (resp_o.rdata !== exp_rdata || resp_o.err !== exp_err) begin
            $display("** Error @ %0t: %s %h gave rdata %h err %b, expected %h err %b",
                     $time, write ? "write" : "read", addr, resp_o.rdata, resp_o.err,
                     exp_rdata, exp_err);
            test_errors++;
        end
        if (n_out != exp_out || n_in != exp_in || (exp_out == 1 && out_ch !== wdata[7:0])) begin
            $display("** Error @ %0t: %h gave %0d out, %0d in, char %h, expected %0d, %0d, %h",
                     $time, addr, n_out, n_in, out_ch, exp_out, exp_in, wdata[7:0]);
            test_errors++;
        end
        uart_count += exp_out;
        @(posedge clock);
        #1;
    endtask

    task automatic apply_reset(input bit check);
        int cnt;
        rst_i = 1'b1;
        repeat (4) @(posedge clock);
        #1;
        rst_i = 1'b0;
        uart_count = 0;
        cnt = 0;
        @(negedge clock);
        while (req_ready_o !== 1'b0 && cnt < TIMEOUT) begin
            cnt++;
            @(negedge clock);
        end
        if (req_ready_o !== 1'b0) begin
            report_timeout("dropped req_ready_o in reset");
        end
        // domain still in reset, port closed
        cnt = 0;
        while (req_ready_o !== 1'b1 && cnt < TIMEOUT) begin
            if (check && (resp_valid_o || uart_out_valid_o || uart_in_valid_o)) begin
                $display("** Error @ %0t: output strobe high during reset", $time);
                test_errors++;
            end
            cnt++;
            @(negedge clock);
        end
        if (req_ready_o !== 1'b1) begin
            report_timeout("raised req_ready_o after reset");
        end
        if (check && cnt != 4) begin
            $display("** Error @ %0t: req_ready_o low for %0d cycles, expected 4", $time, cnt);
            test_errors++;
        end
        @(posedge clock);
        #1;
    endtask

    initial begin
        logic [31:0] a;
        logic [3:0]  s;
        logic        w;
        rst_i = 1'b1;
        req_valid_i = 1'b0;
        req_i = '0;
        uart_in_ch_i = '0;
        lfsr = 16'd73;
        uart_count = 0;
        test_errors = 0;
        errors = 0;
        passed = 0;
        failed = 0;
        apply_reset(1'b0);

        // low window first, later tests only read words written here
        for (int i = 0; i < 64; i++) begin
            run_op(RAM_BASE + i * 4, 1'b1, take_bits(32), 4'hf);
        end
        for (int i = 0; i < 16; i++) begin
            a = RAM_BASE + (take_bits(10) << 2);
            run_op(a, 1'b1, take_bits(32), 4'hf);
            run_op(a, 1'b0, '0, 4'hf);
        end
        for (int i = 0; i < 64; i++) begin
            run_op(RAM_BASE + i * 4, 1'b0, '0, 4'hf);
        end
        finish_test("memory round trip");

        for (int i = 0; i < 40; i++) begin
            a = RAM_BASE + (take_bits(6) << 2);
            s = take_bits(4);
            run_op(a, 1'b1, take_bits(32), s);
            run_op(a, 1'b0, '0, 4'hf);
        end
        finish_test("byte strobes");

        for (int i = 0; i < 20; i++) begin
            run_op(UART_BASE + UART_DATA_OFF, 1'b1, take_bits(32), 4'hf);
        end
        run_op(UART_BASE + UART_STAT_OFF, 1'b0, '0, 4'hf);
        finish_test("uart output");

        for (int i = 0; i < 20; i++) begin
            run_op(UART_BASE + UART_DATA_OFF, 1'b0, '0, 4'hf);
        end
        finish_test("uart input");

        for (int i = 0; i < 20; i++) begin
            a = 32'h4000_0000 | take_bits(28);
            w = take_bits(1);
            run_op(a, w, take_bits(32), 4'hf);
        end
        run_op(RAM_BASE + RAM_WORDS * 4, 1'b1, take_bits(32), 4'hf);
        run_op(UART_BASE + UART_SIZE, 1'b0, '0, 4'hf);
        run_op(UART_BASE + 8, 1'b1, take_bits(32), 4'hf);
        run_op(UART_BASE + 8, 1'b0, '0, 4'hf);
        for (int i = 0; i < 64; i++) begin
            run_op(RAM_BASE + i * 4, 1'b0, '0, 4'hf);
        end
        finish_test("error responses");

        for (int i = 0; i < 200; i++) begin
            case (take_bits(2))
                0, 1: a = RAM_BASE + (take_bits(6) << 2);
                2: a = UART_BASE + (take_bits(2) << 2);
                default: a = 32'h4000_0000 | take_bits(28);
            endcase
            w = take_bits(1);
            s = take_bits(4);
            run_op(a, w, take_bits(32), s);
        end
        apply_reset(1'b1);
        run_op(UART_BASE + UART_STAT_OFF, 1'b0, '0, 4'hf);
        finish_test("mixed run and reset");

        $display("tests: %0d passed, %0d failed, %0d errors", passed, failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: flist.f
design/soc_pkg.sv
design/reset_sync.sv
design/addr_decode.sv
design/apb_bridge.sv
design/sim_uart.sv
design/sim_ram.sv
design/sim_top.sv
bench/tb_sim_top.sv

// File: Makefile
VERILATOR    ?= verilator
TOP          ?= tb_sim_top
FLIST        ?= flist.f
BUILD_DIR    ?= obj_dir
LOG          ?= sim.log
COMMON_FLAGS ?= --timing --timescale 1ns/10ps
LINT_FLAGS   ?= -Wall
SIM_FLAGS    ?= -Wno-fatal
PASS_TEXT    ?= PASS: all tests

SOURCES := $(shell cat $(FLIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(COMMON_FLAGS) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FLIST)
	$(VERILATOR) --binary $(COMMON_FLAGS) $(SIM_FLAGS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FLIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
